// ==== verilog/ahb_pkg.sv ====
// AHB3-Lite bus widths, transfer type, transfer size and response encodings

package ahb_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // Address and data fixed at 32 bits
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;

  // One enable per byte lane
  localparam int BE_W    = HDATA_W / 8;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // HTRANS
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // HSIZE, word and below on a 32-bit bus
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  // Slave never signals an error
  localparam logic HRESP_OKAY = 1'b0;

endpackage

// ==== verilog/timer_pkg.sv ====
// Timer register offsets, register widths and read-select codes

package timer_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // 0x00  prescale
  // 0x04  reserved, reads zero
  // 0x08  interrupt pending, read only
  // 0x0C  interrupt enable
  // 0x10  time, low and high word
  // 0x18  compare n low word at 0x18 + 8n, high word at 0x1C + 8n
  localparam logic [31:0] PRESCALE_OFS = 32'h0000_0000;
  localparam logic [31:0] IPENDING_OFS = 32'h0000_0008;
  localparam logic [31:0] IENABLE_OFS  = 32'h0000_000C;
  localparam logic [31:0] TIME_OFS     = 32'h0000_0010;
  localparam logic [31:0] TIME_MSB_OFS = 32'h0000_0014;
  localparam logic [31:0] TIMECMP_OFS  = 32'h0000_0018;

  // Byte distance between compare registers
  localparam int TIMECMP_STRIDE = 8;

  //////////////////////////////
  // Register widths
  //////////////////////////////

  localparam int TIME_W     = 64;
  localparam int PRESCALE_W = 32;

  // Source of a read word, also reused as register code for writes
  typedef enum logic [2:0] {
    RD_PRESCALE = 3'd0,
    RD_IPENDING = 3'd1,
    RD_IENABLE  = 3'd2,
    RD_TIME_LO  = 3'd3,
    RD_TIME_HI  = 3'd4,
    RD_CMP_LO   = 3'd5,
    RD_CMP_HI   = 3'd6,
    RD_ZERO     = 3'd7
  } rd_sel_t;

endpackage

// ==== verilog/timer_bus_decode.sv ====
// AHB address decode into data-phase write strobes and address-phase read select
`timescale 1ns/1ns

module timer_bus_decode #(
  parameter  int TIMERS      = 3,
  localparam int TIMER_IDX_W = (TIMERS > 1) ? $clog2(TIMERS) : 1
)
(
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        HSEL,
  input  logic [ahb_pkg::HADDR_W-1:0] HADDR,
  input  logic                        HWRITE,
  input  ahb_pkg::hsize_t             HSIZE,
  input  ahb_pkg::htrans_t            HTRANS,
  input  logic                        HREADY,
  output logic                        wr_prescale,
  output logic                        wr_ienable,
  output logic                        wr_time_lo,
  output logic                        wr_time_hi,
  output logic                        wr_cmp_lo,
  output logic                        wr_cmp_hi,
  output logic [TIMER_IDX_W-1:0]      wr_idx,
  output logic [ahb_pkg::BE_W-1:0]    wr_be,
  output timer_pkg::rd_sel_t          rd_sel,
  output logic [TIMER_IDX_W-1:0]      rd_idx
);
  import ahb_pkg::*;
  import timer_pkg::*;

  logic [HADDR_W-1:0] word_ofs;
  logic [HADDR_W-1:0] cmp_ofs;
  logic [HADDR_W-1:0] cmp_slot;
  logic               cmp_hit;
  rd_sel_t            addr_sel;
  logic               wr_xfer;
  logic               wr_pend;
  rd_sel_t            wr_sel;

  // Lane mask for the size, shifted to the addressed byte
  function automatic logic [BE_W-1:0] gen_be(input hsize_t size, input logic [1:0] lane);
    logic [BE_W-1:0] mask;
    case (size)
      HSIZE_BYTE:  mask = 'b1;
      HSIZE_HWORD: mask = 'b11;
      HSIZE_WORD:  mask = '1;
      default:     mask = '1;
    endcase
    return mask << lane;
  endfunction

  //////////////////////////////
  // Address phase
  //////////////////////////////

  always_comb
  begin
    word_ofs = {HADDR[HADDR_W-1:2], 2'b00};
    // Compare slot index and range check
    cmp_ofs  = word_ofs - TIMECMP_OFS;
    cmp_slot = cmp_ofs >> $clog2(TIMECMP_STRIDE);
    cmp_hit  = (word_ofs >= TIMECMP_OFS) && (cmp_slot < TIMERS);
    case (word_ofs)
      PRESCALE_OFS: addr_sel = RD_PRESCALE;
      IPENDING_OFS: addr_sel = RD_IPENDING;
      IENABLE_OFS:  addr_sel = RD_IENABLE;
      TIME_OFS:     addr_sel = RD_TIME_LO;
      TIME_MSB_OFS: addr_sel = RD_TIME_HI;
      default:
      begin
        // Reserved word and compare slots past the last timer
        if (!cmp_hit)
          addr_sel = RD_ZERO;
        else if (cmp_ofs[2])
          addr_sel = RD_CMP_HI;
        else
          addr_sel = RD_CMP_LO;
      end
    endcase
  end

  // Reads use the live address
  assign rd_sel = addr_sel;
  assign rd_idx = cmp_slot[TIMER_IDX_W-1:0];

  // Valid write transfer, no write while HREADY is low
  assign wr_xfer = HSEL && HREADY && HWRITE &&
                   ((HTRANS == HTRANS_NONSEQ) || (HTRANS == HTRANS_SEQ));

  //////////////////////////////
  // Data phase
  //////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wr_pend <= 1'b0;
    else
      wr_pend <= wr_xfer;
  end

  // Address-phase qualifiers held for the data phase
  always_ff @(posedge HCLK)
  begin
    if (wr_xfer)
    begin
      wr_sel <= addr_sel;
      wr_idx <= cmp_slot[TIMER_IDX_W-1:0];
      wr_be  <= gen_be(HSIZE, HADDR[1:0]);
    end
  end

  // One-hot strobes, pending and zero selects raise none
  assign wr_prescale = wr_pend && (wr_sel == RD_PRESCALE);
  assign wr_ienable  = wr_pend && (wr_sel == RD_IENABLE);
  assign wr_time_lo  = wr_pend && (wr_sel == RD_TIME_LO);
  assign wr_time_hi  = wr_pend && (wr_sel == RD_TIME_HI);
  assign wr_cmp_lo   = wr_pend && (wr_sel == RD_CMP_LO);
  assign wr_cmp_hi   = wr_pend && (wr_sel == RD_CMP_HI);

endmodule

// ==== verilog/timer_regs.sv ====
// Prescale, enable, time, compare and interrupt-enable registers with byte-lane writes
`timescale 1ns/1ns

module timer_regs #(
  parameter  int TIMERS      = 3,
  localparam int TIMER_IDX_W = (TIMERS > 1) ? $clog2(TIMERS) : 1
)
(
  input  logic                                     HCLK,
  input  logic                                     HRESETn,
  input  logic                                     wr_prescale,
  input  logic                                     wr_ienable,
  input  logic                                     wr_time_lo,
  input  logic                                     wr_time_hi,
  input  logic                                     wr_cmp_lo,
  input  logic                                     wr_cmp_hi,
  input  logic [TIMER_IDX_W-1:0]                   wr_idx,
  input  logic [ahb_pkg::BE_W-1:0]                 wr_be,
  input  logic [ahb_pkg::HDATA_W-1:0]              HWDATA,
  input  logic                                     count_en,
  output logic [timer_pkg::PRESCALE_W-1:0]         prescale,
  output logic                                     prescale_wr,
  output logic                                     enabled,
  output logic [timer_pkg::TIME_W-1:0]             time_val,
  output logic [TIMERS-1:0][timer_pkg::TIME_W-1:0] cmp_vals,
  output logic [TIMERS-1:0]                        ienable
);
  import ahb_pkg::*;
  import timer_pkg::*;

  logic [HDATA_W-1:0] ienable_ext;
  logic [HDATA_W-1:0] ienable_nxt;

  // Take new bytes where the lane is enabled, keep the rest
  function automatic logic [HDATA_W-1:0] merge_be(
    input logic [HDATA_W-1:0] old_val,
    input logic [HDATA_W-1:0] new_val,
    input logic [BE_W-1:0]    be
  );
    logic [HDATA_W-1:0] res;
    for (int n = 0; n < BE_W; n++)
    begin
      res[n*8 +: 8] = be[n] ? new_val[n*8 +: 8] : old_val[n*8 +: 8];
    end
    return res;
  endfunction

  // Enable bits above TIMERS read as zero and never stick
  always_comb
  begin
    ienable_ext              = '0;
    ienable_ext[TIMERS-1:0]  = ienable;
    ienable_nxt              = merge_be(ienable_ext, HWDATA, wr_be);
  end

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prescale    <= '0;
      prescale_wr <= 1'b0;
      enabled     <= 1'b0;
      ienable     <= '0;
    end
    else
    begin
      // Reload pulse for the prescaler
      prescale_wr <= wr_prescale;
      if (wr_prescale)
      begin
        prescale <= merge_be(prescale, HWDATA, wr_be);
        // First prescale write starts the time counter
        enabled  <= 1'b1;
      end
      if (wr_ienable)
        ienable <= ienable_nxt[TIMERS-1:0];
    end
  end

  // Time counter, a bus write wins over the increment
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      time_val <= '0;
    else if (wr_time_lo || wr_time_hi)
    begin
      if (wr_time_lo)
        time_val[HDATA_W-1:0] <= merge_be(time_val[HDATA_W-1:0], HWDATA, wr_be);
      if (wr_time_hi)
        time_val[TIME_W-1:HDATA_W] <= merge_be(time_val[TIME_W-1:HDATA_W], HWDATA, wr_be);
    end
    else if (count_en)
      time_val <= time_val + 1'b1;
  end

  // Compare registers, one word per strobe
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      cmp_vals <= '0;
    else
    begin
      for (int n = 0; n < TIMERS; n++)
      begin
        if (wr_idx == n)
        begin
          if (wr_cmp_lo)
            cmp_vals[n][HDATA_W-1:0] <= merge_be(cmp_vals[n][HDATA_W-1:0], HWDATA, wr_be);
          if (wr_cmp_hi)
            cmp_vals[n][TIME_W-1:HDATA_W] <=
              merge_be(cmp_vals[n][TIME_W-1:HDATA_W], HWDATA, wr_be);
        end
      end
    end
  end

endmodule

// ==== verilog/timer_prescaler.sv ====
// Prescale down-counter producing the time-count enable
`timescale 1ns/1ns

module timer_prescaler
(
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [timer_pkg::PRESCALE_W-1:0] prescale,
  input  logic                             prescale_wr,
  input  logic                             enabled,
  output logic                             count_en
);
  import timer_pkg::*;

  logic [PRESCALE_W-1:0] cnt;
  logic                  cnt_zero;

  assign cnt_zero = (cnt == '0);

  //////////////////////////////
  // Down-counter
  //////////////////////////////

  // New prescale value restarts the period
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      cnt <= '0;
    else if (prescale_wr || cnt_zero)
      cnt <= prescale;
    else
      cnt <= cnt - 1'b1;
  end

  // One pulse per prescale+1 cycles
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      count_en <= 1'b0;
    else
      count_en <= enabled && cnt_zero;
  end

endmodule

// ==== verilog/timer_compare.sv ====
// Per-timer compare, pending bits and the interrupt output
`timescale 1ns/1ns

module timer_compare #(
  parameter  int TIMERS      = 3,
  localparam int TIMER_IDX_W = (TIMERS > 1) ? $clog2(TIMERS) : 1
)
(
  input  logic                                     HCLK,
  input  logic                                     HRESETn,
  input  logic                                     enabled,
  input  logic [timer_pkg::TIME_W-1:0]             time_val,
  input  logic [TIMERS-1:0][timer_pkg::TIME_W-1:0] cmp_vals,
  input  logic [TIMERS-1:0]                        ienable,
  input  logic                                     wr_cmp_lo,
  input  logic                                     wr_cmp_hi,
  input  logic [TIMER_IDX_W-1:0]                   wr_idx,
  output logic [TIMERS-1:0]                        ipending,
  output logic                                     tint
);

  logic [TIMERS-1:0] cmp_eq;
  logic [TIMERS-1:0] cmp_clr;

  // Equality and compare-write clear per timer
  always_comb
  begin
    for (int n = 0; n < TIMERS; n++)
    begin
      cmp_eq[n]  = (time_val == cmp_vals[n]);
      cmp_clr[n] = (wr_cmp_lo || wr_cmp_hi) && (wr_idx == n);
    end
  end

  //////////////////////////////
  // Pending and interrupt
  //////////////////////////////

  // Nothing pends before the counter runs
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      ipending <= '0;
    else if (enabled)
      ipending <= cmp_eq & ~cmp_clr;
    else
      ipending <= '0;
  end

  // Any enabled pending bit
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      tint <= 1'b0;
    else
      tint <= |(ipending & ienable);
  end

endmodule

// ==== verilog/timer_read_mux.sv ====
// Registered read-data selection for the timer registers
`timescale 1ns/1ns

module timer_read_mux #(
  parameter  int TIMERS      = 3,
  localparam int TIMER_IDX_W = (TIMERS > 1) ? $clog2(TIMERS) : 1
)
(
  input  logic                                     HCLK,
  input  timer_pkg::rd_sel_t                       rd_sel,
  input  logic [TIMER_IDX_W-1:0]                   rd_idx,
  input  logic [timer_pkg::PRESCALE_W-1:0]         prescale,
  input  logic [TIMERS-1:0]                        ipending,
  input  logic [TIMERS-1:0]                        ienable,
  input  logic [timer_pkg::TIME_W-1:0]             time_val,
  input  logic [TIMERS-1:0][timer_pkg::TIME_W-1:0] cmp_vals,
  output logic [ahb_pkg::HDATA_W-1:0]              HRDATA
);
  import ahb_pkg::*;
  import timer_pkg::*;

  logic [HDATA_W-1:0] pending_ext;
  logic [HDATA_W-1:0] enable_ext;

  // Zero-extend the per-timer bit fields
  always_comb
  begin
    pending_ext             = '0;
    pending_ext[TIMERS-1:0] = ipending;
    enable_ext              = '0;
    enable_ext[TIMERS-1:0]  = ienable;
  end

  //////////////////////////////
  // Read data register
  //////////////////////////////

  // Selected in the address phase, valid in the data phase
  always_ff @(posedge HCLK)
  begin
    case (rd_sel)
      RD_PRESCALE: HRDATA <= prescale;
      RD_IPENDING: HRDATA <= pending_ext;
      RD_IENABLE:  HRDATA <= enable_ext;
      RD_TIME_LO:  HRDATA <= time_val[HDATA_W-1:0];
      RD_TIME_HI:  HRDATA <= time_val[TIME_W-1:HDATA_W];
      RD_CMP_LO:   HRDATA <= cmp_vals[rd_idx][HDATA_W-1:0];
      RD_CMP_HI:   HRDATA <= cmp_vals[rd_idx][TIME_W-1:HDATA_W];
      default:     HRDATA <= '0;
    endcase
  end

endmodule

// ==== verilog/ahb_timer.sv ====
// AHB3-Lite timer top level connecting decode, registers, prescaler, compare and read mux
`timescale 1ns/1ns

module ahb_timer #(
  parameter  int TIMERS      = 3,
  localparam int TIMER_IDX_W = (TIMERS > 1) ? $clog2(TIMERS) : 1
)
(
  input  logic                        HCLK,
  input  logic                        HRESETn,
  // AHB slave port, HBURST and HPROT are ignored
  input  logic                        HSEL,
  input  logic [ahb_pkg::HADDR_W-1:0] HADDR,
  input  logic [ahb_pkg::HDATA_W-1:0] HWDATA,
  output logic [ahb_pkg::HDATA_W-1:0] HRDATA,
  input  logic                        HWRITE,
  input  ahb_pkg::hsize_t             HSIZE,
  input  logic [2:0]                  HBURST,
  input  logic [3:0]                  HPROT,
  input  ahb_pkg::htrans_t            HTRANS,
  output logic                        HREADYOUT,
  input  logic                        HREADY,
  output logic                        HRESP,
  // Timer interrupt
  output logic                        tint
);
  import ahb_pkg::*;
  import timer_pkg::*;

  // Decode to registers
  logic                   wr_prescale;
  logic                   wr_ienable;
  logic                   wr_time_lo;
  logic                   wr_time_hi;
  logic                   wr_cmp_lo;
  logic                   wr_cmp_hi;
  logic [TIMER_IDX_W-1:0] wr_idx;
  logic [BE_W-1:0]        wr_be;
  // Decode to read mux
  rd_sel_t                rd_sel;
  logic [TIMER_IDX_W-1:0] rd_idx;
  // Register state
  logic [PRESCALE_W-1:0]         prescale;
  logic                          prescale_wr;
  logic                          enabled;
  logic [TIME_W-1:0]             time_val;
  logic [TIMERS-1:0][TIME_W-1:0] cmp_vals;
  logic [TIMERS-1:0]             ienable;
  logic [TIMERS-1:0]             ipending;
  logic                          count_en;

  // Zero wait states, never an error
  assign HREADYOUT = 1'b1;
  assign HRESP     = HRESP_OKAY;

  //////////////////////////////
  // Instances
  //////////////////////////////

  timer_bus_decode #(.TIMERS(TIMERS)) u_decode (
    .HCLK, .HRESETn, .HSEL, .HADDR, .HWRITE, .HSIZE, .HTRANS, .HREADY,
    .wr_prescale, .wr_ienable, .wr_time_lo, .wr_time_hi, .wr_cmp_lo, .wr_cmp_hi,
    .wr_idx, .wr_be, .rd_sel, .rd_idx
  );

  timer_regs #(.TIMERS(TIMERS)) u_regs (
    .HCLK, .HRESETn,
    .wr_prescale, .wr_ienable, .wr_time_lo, .wr_time_hi, .wr_cmp_lo, .wr_cmp_hi,
    .wr_idx, .wr_be, .HWDATA, .count_en,
    .prescale, .prescale_wr, .enabled, .time_val, .cmp_vals, .ienable
  );

  timer_prescaler u_prescaler (
    .HCLK, .HRESETn, .prescale, .prescale_wr, .enabled, .count_en
  );

  timer_compare #(.TIMERS(TIMERS)) u_compare (
    .HCLK, .HRESETn, .enabled, .time_val, .cmp_vals, .ienable,
    .wr_cmp_lo, .wr_cmp_hi, .wr_idx, .ipending, .tint
  );

  timer_read_mux #(.TIMERS(TIMERS)) u_read_mux (
    .HCLK, .rd_sel, .rd_idx, .prescale, .ipending, .ienable, .time_val, .cmp_vals, .HRDATA
  );

endmodule

// ==== dv/ahb_timer_tb.sv ====
// Testbench for the AHB timer with bus driver tasks, register model, LFSR and assertions
`timescale 1ns/1ns

module ahb_timer_tb;
  import ahb_pkg::*;
  import timer_pkg::*;

  localparam int TIMERS     = 3;
  localparam int MAX_CYCLES = 6000;

  logic               HCLK;
  logic               HRESETn;
  logic               HSEL;
  logic [HADDR_W-1:0] HADDR;
  logic [HDATA_W-1:0] HWDATA;
  logic [HDATA_W-1:0] HRDATA;
  logic               HWRITE;
  hsize_t             HSIZE;
  logic [2:0]         HBURST;
  logic [3:0]         HPROT;
  htrans_t            HTRANS;
  logic               HREADYOUT;
  logic               HREADY;
  logic               HRESP;
  logic               tint;

  // Register model
  logic [31:0] prescale_m;
  logic [31:0] ienable_m;
  logic [63:0] time_m;
  logic [63:0] cmp_m [TIMERS];

  logic [31:0] lfsr;
  int          cycles;
  int          checks;
  int          errors;
  int          tests;

  // Compare and control addresses used by the random test, last two past the last timer
  logic [31:0] rw_addrs [11] = '{PRESCALE_OFS, IPENDING_OFS, IENABLE_OFS,
                                 32'h18, 32'h1C, 32'h20, 32'h24, 32'h28, 32'h2C,
                                 32'h30, 32'h34};

  ahb_timer #(.TIMERS(TIMERS)) UUT (
    .HCLK, .HRESETn, .HSEL, .HADDR, .HWDATA, .HRDATA, .HWRITE, .HSIZE, .HBURST,
    .HPROT, .HTRANS, .HREADYOUT, .HREADY, .HRESP, .tint
  );

  always #20 HCLK = ~HCLK;

  //////////////////////////////
  // Cycle count and timeout
  //////////////////////////////

  always @(posedge HCLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Concurrent checks
  //////////////////////////////

  assert property (@(posedge HCLK) HREADYOUT == 1'b1)
  else
  begin
    $display("[FAIL] %0t HREADYOUT got %0b expected 1", $time, $sampled(HREADYOUT));
    errors++;
  end

  assert property (@(posedge HCLK) HRESP == HRESP_OKAY)
  else
  begin
    $display("[FAIL] %0t HRESP got %0b expected %0b", $time, $sampled(HRESP), HRESP_OKAY);
    errors++;
  end

  // tint needs an enable bit set one cycle earlier
  assert property (@(posedge HCLK) disable iff (!HRESETn)
                   tint |-> ($past(ienable_m) != 0))
  else
  begin
    $display("%0t tint is high while every interrupt enable was off", $time);
    errors++;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Byte lanes touched by a transfer
  function automatic logic [3:0] lane_mask(input hsize_t size, input logic [1:0] lane);
    case (size)
      HSIZE_BYTE:  return 4'b0001 << lane;
      HSIZE_HWORD: return 4'b0011 << lane;
      default:     return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] res;
    for (int n = 0; n < 4; n++)
      res[n*8 +: 8] = be[n] ? new_val[n*8 +: 8] : old_val[n*8 +: 8];
    return res;
  endfunction

  // Expected read word, pending bits taken as zero
  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [31:0] word;
    logic [31:0] slot;
    word = {addr[31:2], 2'b00};
    slot = (word - TIMECMP_OFS) / TIMECMP_STRIDE;
    if (word == PRESCALE_OFS)
      return prescale_m;
    if (word == IENABLE_OFS)
      return ienable_m;
    if (word == TIME_OFS)
      return time_m[31:0];
    if (word == TIME_MSB_OFS)
      return time_m[63:32];
    if ((word >= TIMECMP_OFS) && (slot < TIMERS))
      return word[2] ? cmp_m[slot][63:32] : cmp_m[slot][31:0];
    return '0;
  endfunction

  function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data,
                                      input hsize_t size);
    logic [31:0] word;
    logic [31:0] slot;
    logic [3:0]  be;
    word = {addr[31:2], 2'b00};
    slot = (word - TIMECMP_OFS) / TIMECMP_STRIDE;
    be   = lane_mask(size, addr[1:0]);
    if (word == PRESCALE_OFS)
      prescale_m = merge_lanes(prescale_m, data, be);
    else if (word == IENABLE_OFS)
      ienable_m = merge_lanes(ienable_m, data, be) & ((32'h1 << TIMERS) - 1);
    else if (word == TIME_OFS)
      time_m[31:0] = merge_lanes(time_m[31:0], data, be);
    else if (word == TIME_MSB_OFS)
      time_m[63:32] = merge_lanes(time_m[63:32], data, be);
    else if ((word >= TIMECMP_OFS) && (slot < TIMERS))
    begin
      if (word[2])
        cmp_m[slot][63:32] = merge_lanes(cmp_m[slot][63:32], data, be);
      else
        cmp_m[slot][31:0] = merge_lanes(cmp_m[slot][31:0], data, be);
    end
  endfunction

  // Address phase, then data phase with HWDATA
  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                           input hsize_t size);
    @(posedge HCLK);
    #2;
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = 1'b1;
    HSIZE  = size;
    HTRANS = HTRANS_NONSEQ;
    @(posedge HCLK);
    #2;
    HSEL   = 1'b0;
    HWRITE = 1'b0;
    HTRANS = HTRANS_IDLE;
    HWDATA = data;
    @(posedge HCLK);
  endtask

  // HRDATA sampled inside the data phase
  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge HCLK);
    #2;
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = 1'b0;
    HSIZE  = HSIZE_WORD;
    HTRANS = HTRANS_NONSEQ;
    @(posedge HCLK);
    #2;
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    data   = HRDATA;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input hsize_t size);
    ahb_write(addr, data, size);
    apply_write(addr, data, size);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_read(input logic [31:0] addr);
    logic [31:0] got;
    ahb_read(addr, got);
    check_word($sformatf("HRDATA@%02h", addr), got, model_word(addr));
  endtask

  task automatic read_time(output logic [63:0] val);
    logic [31:0] lo;
    logic [31:0] hi;
    ahb_read(TIME_OFS, lo);
    ahb_read(TIME_MSB_OFS, hi);
    val = {hi, lo};
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("Test %-14s %s, %0d errors", name,
             (errors == err_before) ? "ok" : "with errors", errors - err_before);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    int          err0;
    int          c0;
    int          k;
    int          q;
    int          limit;
    logic [31:0] got;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] p;
    logic [31:0] addr;
    logic [63:0] now;
    logic [63:0] target;
    hsize_t      size;

    HCLK       = 1'b0;
    HRESETn    = 1'b0;
    HSEL       = 1'b0;
    HADDR      = '0;
    HWDATA     = '0;
    HWRITE     = 1'b0;
    HSIZE      = HSIZE_WORD;
    HBURST     = '0;
    HPROT      = 4'b0011;
    HTRANS     = HTRANS_IDLE;
    HREADY     = 1'b1;
    lfsr       = 32'h5b6b716a;
    cycles     = 0;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    prescale_m = '0;
    ienable_m  = '0;
    time_m     = '0;
    for (int n = 0; n < TIMERS; n++)
      cmp_m[n] = '0;

    repeat (16) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;

    // Every register and the reserved word read zero
    err0 = errors;
    check_word("tint", {31'b0, tint}, 32'h0);
    foreach (rw_addrs[i])
      expect_read(rw_addrs[i]);
    expect_read(TIME_OFS);
    expect_read(TIME_MSB_OFS);
    expect_read(32'h04);
    report_test("reset_state", err0);

    // Time holds until the first prescale write
    err0 = errors;
    write_reg(TIME_OFS, 32'h0000_1000 + rand_bits(8), HSIZE_WORD);
    write_reg(TIME_MSB_OFS, 32'h0000_0001 + rand_bits(8), HSIZE_WORD);
    expect_read(TIME_OFS);
    repeat (40) @(posedge HCLK);
    expect_read(TIME_OFS);
    expect_read(TIME_MSB_OFS);
    // Rate after prescale P, reads timed by the cycle counter
    p = 2 + rand_bits(3);
    write_reg(PRESCALE_OFS, p, HSIZE_WORD);
    ahb_read(TIME_OFS, t0);
    c0 = cycles;
    repeat (200) @(posedge HCLK);
    ahb_read(TIME_OFS, t1);
    k = cycles - c0;
    q = k / (p + 1);
    checks++;
    assert ((t1 - t0 >= q - 1) && (t1 - t0 <= q + 1))
    else
    begin
      $display("[FAIL] %0t time_delta got %0d expected %0d..%0d", $time, t1 - t0, q - 1, q + 1);
      errors++;
    end
    report_test("counting_rate", err0);

    // Random sizes and lanes, read back after each write
    err0 = errors;
    for (int i = 0; i < 40; i++)
    begin
      addr = rw_addrs[rand_bits(4) % 11];
      case (rand_bits(2) % 3)
        0:
        begin
          size = HSIZE_BYTE;
          addr = addr | rand_bits(2);
        end
        1:
        begin
          size = HSIZE_HWORD;
          addr = addr | {rand_bits(1), 1'b0};
        end
        default:
          size = HSIZE_WORD;
      endcase
      write_reg(addr, rand_bits(32), size);
      expect_read(addr);
    end
    foreach (rw_addrs[i])
      expect_read(rw_addrs[i]);
    report_test("register_rw", err0);

    // Timer 1 a few ticks ahead, 16 cycles per tick
    err0 = errors;
    write_reg(PRESCALE_OFS, 32'd15, HSIZE_WORD);
    write_reg(IENABLE_OFS, 32'h2, HSIZE_WORD);
    read_time(now);
    target = now + 3;
    write_reg(TIMECMP_OFS + TIMECMP_STRIDE + 4, target[63:32], HSIZE_WORD);
    write_reg(TIMECMP_OFS + TIMECMP_STRIDE, target[31:0], HSIZE_WORD);
    limit = 5 * 16 + 8;
    c0    = cycles;
    while (!tint && (cycles - c0 < limit))
    begin
      @(posedge HCLK);
      #2;
    end
    if (!tint)
    begin
      $display("tint did not rise within %0d cycles of the compare write", limit);
      errors++;
    end
    ahb_read(IPENDING_OFS, got);
    check_word("IPENDING", got, 32'h2);
    // Moving the compare ahead drops pending and tint
    write_reg(TIMECMP_OFS + TIMECMP_STRIDE, target[31:0] + 100, HSIZE_WORD);
    repeat (3) @(posedge HCLK);
    #2;
    check_word("tint", {31'b0, tint}, 32'h0);
    ahb_read(IPENDING_OFS, got);
    check_word("IPENDING", got, 32'h0);
    report_test("interrupt", err0);

    // Timer 2 reached with every enable off
    err0 = errors;
    write_reg(IENABLE_OFS, 32'h0, HSIZE_WORD);
    read_time(now);
    target = now + 2;
    write_reg(TIMECMP_OFS + 2 * TIMECMP_STRIDE + 4, target[63:32], HSIZE_WORD);
    write_reg(TIMECMP_OFS + 2 * TIMECMP_STRIDE, target[31:0], HSIZE_WORD);
    got = '0;
    for (int i = 0; (i < 40) && !got[2]; i++)
    begin
      ahb_read(IPENDING_OFS, got);
      check_word("tint", {31'b0, tint}, 32'h0);
    end
    check_word("IPENDING", got, 32'h4);
    report_test("masked_irq", err0);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== ahb_timer.f ====
verilog/ahb_pkg.sv
verilog/timer_pkg.sv
verilog/timer_bus_decode.sv
verilog/timer_regs.sv
verilog/timer_prescaler.sv
verilog/timer_compare.sv
verilog/timer_read_mux.sv
verilog/ahb_timer.sv
dv/ahb_timer_tb.sv

// ==== Bender.yml ====
package:
  name: ahb_timer

sources:
  # Packages first, then the RTL in compile order
  - files:
      - verilog/ahb_pkg.sv
      - verilog/timer_pkg.sv
      - verilog/timer_bus_decode.sv
      - verilog/timer_regs.sv
      - verilog/timer_prescaler.sv
      - verilog/timer_compare.sv
      - verilog/timer_read_mux.sv
      - verilog/ahb_timer.sv

  # Testbench
  - target: test
    files:
      - dv/ahb_timer_tb.sv
